// ==== glb_pkg.sv ====
// Shared widths, bank request and read tag structs, and the APB address decoding
// for the global buffer bank
`default_nettype none

package glb_pkg;

    // APB side
    localparam int GLB_ADDR_W = 16;
    localparam int GLB_DATA_W = 32;
    localparam int GLB_STRB_W = GLB_DATA_W / 8;

    // SRAM side
    localparam int GLB_WORD_W = 64;
    localparam int GLB_MACRO_ROW_W = 11;
    localparam int GLB_ROW_W = 12;

    // Byte address split into bank row, bank, 32-bit lane and byte offset
    typedef struct packed {
        logic [GLB_ROW_W-1:0] row;
        logic                 bank;
        logic                 lane;
        logic [1:0]           byte_off;
    } glb_addr_fields_t;

    typedef union packed {
        logic [GLB_ADDR_W-1:0] flat;
        glb_addr_fields_t      fields;
    } glb_addr_u;

    // One request to a bank, macro style active-low controls
    typedef struct packed {
        logic                  ceb;
        logic                  web;
        logic [GLB_WORD_W-1:0] bweb;
        logic [GLB_ROW_W-1:0]  row;
        logic [GLB_WORD_W-1:0] d;
    } glb_req_t;

    // Where the data of an issued read comes back
    typedef struct packed {
        logic bank;
        logic lane;
    } glb_rd_tag_t;

endpackage

`default_nettype wire

// ==== sram_2048x64.sv ====
// Behavioral single-port 2048x64 SRAM macro
// Active-low enables, per-bit write mask, one cycle read latency
`timescale 1ns/1ps
`default_nettype none

module sram_2048x64 (
    input  logic                                CLK,
    input  logic                                ceb,
    input  logic                                web,
    input  logic [glb_pkg::GLB_WORD_W-1:0]      bweb,
    input  logic [glb_pkg::GLB_MACRO_ROW_W-1:0] a,
    input  logic [glb_pkg::GLB_WORD_W-1:0]      d,
    output logic [glb_pkg::GLB_WORD_W-1:0]      q
);

    import glb_pkg::*;

    logic [GLB_WORD_W-1:0] mem [0:(1 << GLB_MACRO_ROW_W)-1];

    // Bits with bweb low take the new data, the rest keep the stored value
    always_ff @(posedge CLK) begin
        if (!ceb && !web) begin
            mem[a] <= (mem[a] & bweb) | (d & ~bweb);
        end
    end

    // Q only changes on an enabled read
    always_ff @(posedge CLK) begin
        if (!ceb && web) begin
            q <= mem[a];
        end
    end

endmodule

`default_nettype wire

// ==== glb_bank_sram_gen.sv ====
// Bank generator tiling 2048x64 macros up to 2**ADDR_WIDTH rows
// with macro select decode and registered read select
`timescale 1ns/1ps
`default_nettype none

module glb_bank_sram_gen #(
    parameter int ADDR_WIDTH = glb_pkg::GLB_ROW_W
) (
    input  logic                           CLK,
    input  glb_pkg::glb_req_t              req,
    output logic [glb_pkg::GLB_WORD_W-1:0] q
);

    import glb_pkg::*;

    localparam int SEL_W = ADDR_WIDTH - GLB_MACRO_ROW_W;
    localparam int NUM_MACRO = 1 << SEL_W;
    // Keeps the select vectors legal when a single macro is enough
    localparam int SEL_BITS = (SEL_W > 0) ? SEL_W : 1;

    logic [ADDR_WIDTH-1:0]      a;
    logic [GLB_MACRO_ROW_W-1:0] macro_a;
    logic [SEL_BITS-1:0]        mem_sel;
    logic [SEL_BITS-1:0]        out_sel;
    logic [NUM_MACRO-1:0]       web_arr;
    logic [GLB_WORD_W-1:0]      q_arr [NUM_MACRO];

    assign a = ADDR_WIDTH'(req.row);
    assign macro_a = a[GLB_MACRO_ROW_W-1:0];

    generate
        if (SEL_W > 0) begin : g_sel
            assign mem_sel = a[ADDR_WIDTH-1:GLB_MACRO_ROW_W];
        end else begin : g_no_sel
            assign mem_sel = '0;
        end
    endgenerate

    // Only the addressed macro may write
    always_comb begin
        for (int i = 0; i < NUM_MACRO; i++) begin
            web_arr[i] = req.web | (mem_sel != SEL_BITS'(i));
        end
    end

    // Remember which macro a read went to, held until the next read
    always_ff @(posedge CLK) begin
        if (!req.ceb && req.web) begin
            out_sel <= mem_sel;
        end
    end

    assign q = q_arr[out_sel];

    for (genvar i = 0; i < NUM_MACRO; i++) begin : g_macro
        sram_2048x64 sram_i (
            .CLK  (CLK),
            .ceb  (req.ceb),
            .web  (web_arr[i]),
            .bweb (req.bweb),
            .a    (macro_a),
            .d    (req.d),
            .q    (q_arr[i])
        );
    end

endmodule

`default_nettype wire

// ==== glb_apb_ctrl.sv ====
// APB slave for the global buffer: address decode, per-bank requests,
// byte strobe masking and PREADY timing with one read wait state
`timescale 1ns/1ps
`default_nettype none

module glb_apb_ctrl (
    input  logic                            CLK,
    input  logic                            reset,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [glb_pkg::GLB_ADDR_W-1:0]  paddr,
    input  logic [glb_pkg::GLB_DATA_W-1:0]  pwdata,
    input  logic [glb_pkg::GLB_STRB_W-1:0]  pstrb,
    output logic                            pready,
    output glb_pkg::glb_req_t [1:0]         bank_req,
    output logic                            rd_issue,
    output glb_pkg::glb_rd_tag_t            rd_tag
);

    import glb_pkg::*;

    glb_addr_u             addr;
    logic                  rd_pend;
    logic                  access;
    logic [GLB_DATA_W-1:0] lane_mask;
    logic [GLB_WORD_W-1:0] wr_bweb;

    assign addr.flat = paddr;

    // First access cycle of a transfer, the only cycle an SRAM is enabled
    assign access = psel & penable & ~rd_pend;

    assign rd_issue = access & ~pwrite;

    // Writes finish at once, reads after the wait state
    assign pready = psel & penable & (pwrite | rd_pend);

    // The cycle after a read issue is always the completing one
    always_ff @(posedge CLK) begin
        if (reset) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= rd_issue;
        end
    end

    // Strobe bits to active-low byte masks within one 32-bit lane
    always_comb begin
        lane_mask = '1;
        for (int i = 0; i < GLB_STRB_W; i++) begin
            if (pstrb[i]) begin
                lane_mask[i*8 +: 8] = 8'h00;
            end
        end
    end

    // Untouched lane keeps all its bits
    assign wr_bweb = addr.fields.lane ? {lane_mask, {GLB_DATA_W{1'b1}}}
                                      : {{GLB_DATA_W{1'b1}}, lane_mask};

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            bank_req[b].ceb  = ~(access & (addr.fields.bank == 1'(b)));
            bank_req[b].web  = ~pwrite;
            bank_req[b].bweb = pwrite ? wr_bweb : '1;
            bank_req[b].row  = addr.fields.row;
            // Same word on both lanes, bweb picks the live one
            bank_req[b].d    = {pwdata, pwdata};
        end
    end

    assign rd_tag.bank = addr.fields.bank;
    assign rd_tag.lane = addr.fields.lane;

endmodule

`default_nettype wire

// ==== glb_read_merge.sv ====
// Read merge: captures the read tag and steers bank and lane onto PRDATA
`timescale 1ns/1ps
`default_nettype none

module glb_read_merge (
    input  logic                           CLK,
    input  logic                           reset,
    input  logic                           rd_issue,
    input  glb_pkg::glb_rd_tag_t           rd_tag,
    input  logic [glb_pkg::GLB_WORD_W-1:0] bank_q [1:0],
    output logic [glb_pkg::GLB_DATA_W-1:0] prdata
);

    import glb_pkg::*;

    glb_rd_tag_t           tag_q;
    logic [GLB_WORD_W-1:0] word;

    // Bank data shows up one clock after the issue, so hold the tag
    always_ff @(posedge CLK) begin
        if (reset) begin
            tag_q <= '0;
        end else if (rd_issue) begin
            tag_q <= rd_tag;
        end
    end

    assign word = bank_q[tag_q.bank];

    // Lane 1 is the upper half of the 64-bit row
    assign prdata = tag_q.lane ? word[GLB_WORD_W-1:GLB_DATA_W] : word[GLB_DATA_W-1:0];

endmodule

`default_nettype wire

// ==== glb_bank_top.sv ====
// Global buffer top: APB controller, two interleaved banks and the read merge
`timescale 1ns/1ps
`default_nettype none

module glb_bank_top (
    input  logic                           CLK,
    input  logic                           reset,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [glb_pkg::GLB_ADDR_W-1:0] paddr,
    input  logic [glb_pkg::GLB_DATA_W-1:0] pwdata,
    input  logic [glb_pkg::GLB_STRB_W-1:0] pstrb,
    output logic                           pready,
    output logic [glb_pkg::GLB_DATA_W-1:0] prdata
);

    import glb_pkg::*;

    glb_req_t [1:0]        bank_req;
    logic                  rd_issue;
    glb_rd_tag_t           rd_tag;
    logic [GLB_WORD_W-1:0] bank_q [1:0];

    glb_apb_ctrl ctrl_i (
        .CLK      (CLK),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .pready   (pready),
        .bank_req (bank_req),
        .rd_issue (rd_issue),
        .rd_tag   (rd_tag)
    );

    // Even 64-bit words
    glb_bank_sram_gen #(.ADDR_WIDTH(GLB_ROW_W)) bank0_i (
        .CLK (CLK),
        .req (bank_req[0]),
        .q   (bank_q[0])
    );

    // Odd 64-bit words
    glb_bank_sram_gen #(.ADDR_WIDTH(GLB_ROW_W)) bank1_i (
        .CLK (CLK),
        .req (bank_req[1]),
        .q   (bank_q[1])
    );

    glb_read_merge merge_i (
        .CLK      (CLK),
        .reset    (reset),
        .rd_issue (rd_issue),
        .rd_tag   (rd_tag),
        .bank_q   (bank_q),
        .prdata   (prdata)
    );

endmodule

`default_nettype wire

// ==== glb_bank_chk.sv ====
// Concurrent assertions on APB handshake and bank enables of the global buffer
`timescale 1ns/1ps
`default_nettype none

module glb_bank_chk (
    input logic                    CLK,
    input logic                    reset,
    input logic                    psel,
    input logic                    penable,
    input logic                    pwrite,
    input logic                    pready,
    input glb_pkg::glb_req_t [1:0] bank_req
);

    // Number of failed assertions
    int fail_count = 0;

    // PREADY only inside an access phase
    a_ready_in_access: assert property (
        @(posedge CLK) disable iff (reset)
        pready |-> (psel && penable)
    ) else begin
        fail_count++;
        $error("PREADY high outside an APB access phase");
    end

    a_ready_low_after_reset: assert property (
        @(posedge CLK)
        reset |=> !pready
    ) else begin
        fail_count++;
        $error("PREADY high in the cycle after reset");
    end

    // Interleaved banks are never enabled together
    a_one_bank: assert property (
        @(posedge CLK) disable iff (reset)
        !(!bank_req[0].ceb && !bank_req[1].ceb)
    ) else begin
        fail_count++;
        $error("both bank chip enables low in the same cycle");
    end

    // First access cycle of a read is always a wait state
    a_read_wait: assert property (
        @(posedge CLK) disable iff (reset)
        (psel && penable && !pwrite && !$past(penable)) |-> !pready
    ) else begin
        fail_count++;
        $error("read completed in its first access cycle");
    end

endmodule

bind glb_bank_top glb_bank_chk chk_i (
    .CLK      (CLK),
    .reset    (reset),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pready   (pready),
    .bank_req (bank_req)
);

`default_nettype wire

// ==== glb_bank_tb.sv ====
// Testbench for the global buffer bank: APB driver tasks, byte-masked memory model,
// directed and random transfers with compare tasks
`timescale 1ns/1ps
`default_nettype none

module glb_bank_tb;

    import glb_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int XFER_TIMEOUT = 16;
    localparam int WATCHDOG_NS = 2_000_000;
    localparam int NUM_RANDOM = 2000;
    localparam int POOL_SIZE = 8;
    localparam int MODEL_DEPTH = 1 << (GLB_ADDR_W - 2);

    logic                  CLK;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [GLB_ADDR_W-1:0] paddr;
    logic [GLB_DATA_W-1:0] pwdata;
    logic [GLB_STRB_W-1:0] pstrb;
    logic                  pready;
    logic [GLB_DATA_W-1:0] prdata;

    // One 32-bit word per lane, plus which of its bytes were ever written
    logic [GLB_DATA_W-1:0] model_mem [MODEL_DEPTH];
    logic [GLB_STRB_W-1:0] model_vld [MODEL_DEPTH];
    logic [GLB_ADDR_W-1:0] pool [POOL_SIZE];
    int rdata_errs;
    int wait_errs;
    int other_errs;

    glb_bank_top dut_i (
        .CLK     (CLK),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test reached its end");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // Word index is the byte address without byte_off
    function automatic int model_index(input logic [GLB_ADDR_W-1:0] addr);
        glb_addr_u a;
        a.flat = addr;
        return int'({a.fields.row, a.fields.bank, a.fields.lane});
    endfunction

    function automatic logic [GLB_DATA_W-1:0] model_mask(input logic [GLB_ADDR_W-1:0] addr);
        logic [GLB_DATA_W-1:0] mask;
        int idx;
        idx = model_index(addr);
        for (int i = 0; i < GLB_STRB_W; i++) begin
            mask[i*8 +: 8] = {8{model_vld[idx][i]}};
        end
        return mask;
    endfunction

    function automatic logic [GLB_ADDR_W-1:0] rand_addr();
        logic [31:0] r;
        r = $urandom;
        return {r[GLB_ADDR_W-1:2], 2'b00};
    endfunction

    task automatic model_write(input logic [GLB_ADDR_W-1:0] addr,
                               input logic [GLB_DATA_W-1:0] data,
                               input logic [GLB_STRB_W-1:0] strb);
        int idx;
        idx = model_index(addr);
        for (int i = 0; i < GLB_STRB_W; i++) begin
            if (strb[i]) begin
                model_mem[idx][i*8 +: 8] = data[i*8 +: 8];
                model_vld[idx][i] = 1'b1;
            end
        end
    endtask

    // Bytes never written are left out of the compare
    task automatic check_rdata(input logic [GLB_ADDR_W-1:0] addr,
                               input logic [GLB_DATA_W-1:0] exp,
                               input logic [GLB_DATA_W-1:0] act,
                               input logic [GLB_DATA_W-1:0] mask);
        if (((exp ^ act) & mask) !== '0) begin
            rdata_errs++;
            $display("mismatch prdata at paddr 0x%h: expected 0x%h actual 0x%h (byte mask 0x%h)",
                     addr, exp & mask, act, mask);
        end
    endtask

    task automatic check_wait(input string kind, input logic [GLB_ADDR_W-1:0] addr,
                              input int exp, input int act);
        if (act != exp) begin
            wait_errs++;
            $display("%s at paddr 0x%h took %0d access cycles instead of %0d",
                     kind, addr, act, exp);
        end
    endtask

    // Setup phase, then access phase until PREADY; back-to-back with the next call
    task automatic run_xfer(input logic wr, input logic [GLB_ADDR_W-1:0] addr,
                            input logic [GLB_DATA_W-1:0] wdata,
                            input logic [GLB_STRB_W-1:0] strb,
                            output logic [GLB_DATA_W-1:0] rdata, output int cycles);
        logic done;
        done = 1'b0;
        cycles = 0;
        rdata = '0;
        @(negedge CLK);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wr ? wdata : '0;
        pstrb = wr ? strb : '0;
        #(CLK_PERIOD / 4);
        if (pready !== 1'b0) begin
            other_errs++;
            $display("PREADY was not low in the setup phase at paddr 0x%h", addr);
        end
        @(negedge CLK);
        penable = 1'b1;
        while (!done && cycles < XFER_TIMEOUT) begin
            #(CLK_PERIOD / 4);
            cycles++;
            if (pready === 1'b1) begin
                done = 1'b1;
                rdata = prdata;
            end else begin
                @(negedge CLK);
            end
        end
        if (!done) begin
            other_errs++;
            $display("timeout waiting for PREADY at paddr 0x%h", addr);
        end
    endtask

    task automatic do_write(input logic [GLB_ADDR_W-1:0] addr,
                            input logic [GLB_DATA_W-1:0] data,
                            input logic [GLB_STRB_W-1:0] strb);
        logic [GLB_DATA_W-1:0] rd_unused;
        int cycles;
        run_xfer(1'b1, addr, data, strb, rd_unused, cycles);
        check_wait("write", addr, 1, cycles);
        model_write(addr, data, strb);
    endtask

    task automatic do_read(input logic [GLB_ADDR_W-1:0] addr);
        logic [GLB_DATA_W-1:0] rd;
        int cycles;
        run_xfer(1'b0, addr, '0, '0, rd, cycles);
        check_wait("read", addr, 2, cycles);
        check_rdata(addr, model_mem[model_index(addr)], rd, model_mask(addr));
    endtask

    task automatic go_idle();
        @(negedge CLK);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    initial begin
        logic [GLB_ADDR_W-1:0] base;
        logic [GLB_ADDR_W-1:0] addr;
        int assert_errs;
        void'($urandom(15));
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pstrb = '0;
        rdata_errs = 0;
        wait_errs = 0;
        other_errs = 0;
        for (int i = 0; i < MODEL_DEPTH; i++) begin
            model_vld[i] = '0;
        end
        repeat (2) @(negedge CLK);
        reset = 1'b0;

        // Idle bus after reset
        repeat (3) begin
            @(negedge CLK);
            #(CLK_PERIOD / 4);
            if (pready !== 1'b0) begin
                other_errs++;
                $display("PREADY was not low on the idle bus after reset");
            end
        end

        // Full words on both lanes of a row
        for (int i = 0; i < 8; i++) begin
            base = rand_addr() & 16'hfff8;
            do_write(base, $urandom, 4'hf);
            do_write(base | 16'h0004, $urandom, 4'hf);
            do_read(base);
            do_read(base | 16'h0004);
        end

        // Partial strobes, neighbor lane must keep its word
        for (int i = 0; i < 64; i++) begin
            addr = rand_addr();
            do_write(addr, $urandom, 4'hf);
            do_write(addr ^ 16'h0004, $urandom, 4'hf);
            do_write(addr, $urandom, 4'($urandom));
            do_read(addr);
            do_read(addr ^ 16'h0004);
        end

        // Bank bit 3 and macro select bit 15
        for (int i = 0; i < 8; i++) begin
            base = rand_addr() & 16'h7ff4;
            do_write(base, {16'(i), 16'h0b00}, 4'hf);
            do_write(base | 16'h0008, {16'(i), 16'h0b01}, 4'hf);
            do_write(base | 16'h8000, {16'(i), 16'h0b80}, 4'hf);
            do_write(base | 16'h8008, {16'(i), 16'h0b81}, 4'hf);
            do_read(base);
            do_read(base | 16'h0008);
            do_read(base | 16'h8000);
            do_read(base | 16'h8008);
        end

        // Random mix, half from a small pool for read-after-write hits
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = rand_addr();
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if ($urandom_range(1, 0) == 0) begin
                addr = pool[$urandom_range(POOL_SIZE - 1, 0)];
            end else begin
                addr = rand_addr();
            end
            if ($urandom_range(1, 0) == 1) begin
                do_write(addr, $urandom, 4'($urandom));
            end else begin
                do_read(addr);
            end
        end
        go_idle();
        repeat (2) @(negedge CLK);

        assert_errs = dut_i.chk_i.fail_count;
        $display("errors: %0d prdata, %0d wait state, %0d other, %0d assertion",
                 rdata_errs, wait_errs, other_errs, assert_errs);
        if (rdata_errs + wait_errs + other_errs + assert_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
glb_pkg.sv
sram_2048x64.sv
glb_bank_sram_gen.sv
glb_apb_ctrl.sv
glb_read_merge.sv
glb_bank_top.sv
glb_bank_chk.sv
glb_bank_tb.sv

// ==== Makefile ====
# Verilator flow for the global buffer bank testbench

VERILATOR   ?= verilator
TOP         ?= glb_bank_tb
FLIST       ?= compile.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0
FAIL_MSG    ?= *** TEST FAILED ***
PASS_MSG    ?= *** TEST PASSED ***

SRCS := $(shell cat $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
